//--- Bender.yml
package:
  name: fetch_unit

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fetch_pkg.sv
      - hdl/inst_predecode.sv
      - hdl/stall_tracker.sv
      - hdl/pc_sequencer.sv
      - hdl/fetch_unit.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/fetch_unit_tb.sv

//--- hdl/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// datapath word width
`define FETCH_XLEN 32

// program counter after reset
`define FETCH_RESET_PC 32'h8000_0000

// rv32 major opcodes seen by the predecoder
`define FETCH_OP_JAL    7'b1101111
`define FETCH_OP_JALR   7'b1100111
`define FETCH_OP_BRANCH 7'b1100011
`define FETCH_OP_OP     7'b0110011

// funct7 of the m extension group in OP
`define FETCH_F7_MULDIV 7'b0000001

`endif

//--- hdl/fetch_pkg.sv
`include "fetch_defines.svh"

package fetch_pkg;

    // j-type view, imm holds inst[31:12] in encoded bit order
    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } j_type_t;

    // b-type view, immediate split over inst[31:25] and inst[11:7]
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef union packed {
        j_type_t j;
        b_type_t b;
        r_type_t r;
    } instr_t;

    typedef enum logic [2:0] {
        cls_seq,
        cls_jal,
        cls_branch,
        cls_jalr,
        cls_mul,
        cls_div
    } inst_class_e;

    typedef struct packed {
        logic                   valid;
        inst_class_e            cls;
        logic [`FETCH_XLEN-1:0] next_pc;
        logic [`FETCH_XLEN-1:0] pc;
    } predecode_t;

    typedef struct packed {
        logic                   mul_done;
        logic                   div_done;
        logic                   jalr_valid;
        logic [`FETCH_XLEN-1:0] jalr_target;
        logic                   redirect;
        logic [`FETCH_XLEN-1:0] redirect_target;
    } exec_event_t;

    typedef struct packed {
        logic                   hold;
        logic                   go;
        logic [`FETCH_XLEN-1:0] go_target;
    } release_t;

    typedef struct packed {
        logic                   valid;
        logic [`FETCH_XLEN-1:0] pc;
        instr_t                 inst;
    } fetch_out_t;

endpackage

//--- hdl/fetch_unit.sv
`timescale 1ns/1ps

`include "fetch_defines.svh"

module fetch_unit
    import fetch_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   rsp_valid,
    input  instr_t                 rsp_data,
    input  exec_event_t            exec,
    output logic                   fetch_req,
    output logic [`FETCH_XLEN-1:0] fetch_pc,
    output fetch_out_t             fout
);

    predecode_t             pre;
    release_t               rel;
    logic [`FETCH_XLEN-1:0] cur_pc;
    instr_t                 rsp_word;

    // classify the returning word against the pc it was fetched from
    inst_predecode predecode_i (
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_word),
        .rsp_pc    (cur_pc),
        .pre       (pre)
    );

    stall_tracker stall_i (
        .clk   (clk),
        .rst_n (rst_n),
        .pre   (pre),
        .exec  (exec),
        .rel   (rel)
    );

    pc_sequencer sequencer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .pre       (pre),
        .rel       (rel),
        .exec      (exec),
        .fetch_req (fetch_req),
        .fetch_pc  (fetch_pc),
        .fout      (fout),
        .cur_pc    (cur_pc),
        .rsp_word  (rsp_word)
    );

endmodule

//--- hdl/inst_predecode.sv
`timescale 1ns/1ps

`include "fetch_defines.svh"

module inst_predecode
    import fetch_pkg::*;
(
    input  logic                   rsp_valid,
    input  instr_t                 rsp_data,
    input  logic [`FETCH_XLEN-1:0] rsp_pc,
    output predecode_t             pre
);

    logic [`FETCH_XLEN-1:0] imm_j;
    logic [`FETCH_XLEN-1:0] imm_b;
    logic [`FETCH_XLEN-1:0] seq_pc;
    logic [`FETCH_XLEN-1:0] next_pc;
    logic                   is_jal;
    logic                   is_jalr;
    logic                   is_branch;
    logic                   is_muldiv;
    logic                   is_mul;
    logic                   is_div;
    inst_class_e            cls;

    // imm[20|10:1|11|19:12] sits in inst[31:12]
    assign imm_j = {{11{rsp_data.j.imm[19]}}, rsp_data.j.imm[19], rsp_data.j.imm[7:0],
                    rsp_data.j.imm[8], rsp_data.j.imm[18:9], 1'b0};

    // imm[12|10:5] high and imm[4:1|11] low
    assign imm_b = {{19{rsp_data.b.imm_hi[6]}}, rsp_data.b.imm_hi[6], rsp_data.b.imm_lo[0],
                    rsp_data.b.imm_hi[5:0], rsp_data.b.imm_lo[4:1], 1'b0};

    assign seq_pc = rsp_pc + `FETCH_XLEN'd4;

    assign is_jal    = (rsp_data.j.opcode == `FETCH_OP_JAL);
    assign is_jalr   = (rsp_data.r.opcode == `FETCH_OP_JALR);
    assign is_branch = (rsp_data.b.opcode == `FETCH_OP_BRANCH);
    assign is_muldiv = (rsp_data.r.opcode == `FETCH_OP_OP) &&
                       (rsp_data.r.funct7 == `FETCH_F7_MULDIV);

    // funct3 msb splits mul* from div*/rem*
    assign is_mul = is_muldiv && !rsp_data.r.funct3[2];
    assign is_div = is_muldiv && rsp_data.r.funct3[2];

    always_comb begin
        if (is_jal) begin
            cls = cls_jal;
        end else if (is_jalr) begin
            cls = cls_jalr;
        end else if (is_branch) begin
            cls = cls_branch;
        end else if (is_mul) begin
            cls = cls_mul;
        end else if (is_div) begin
            cls = cls_div;
        end else begin
            cls = cls_seq;
        end
    end

    always_comb begin
        case (cls)
            cls_jal: begin
                next_pc = rsp_pc + imm_j;
            end
            cls_branch: begin
                // backward taken and forward not taken
                next_pc = imm_b[`FETCH_XLEN-1] ? rsp_pc + imm_b : seq_pc;
            end
            default: begin
                next_pc = seq_pc;
            end
        endcase
    end

    assign pre = '{valid: rsp_valid, cls: cls, next_pc: next_pc, pc: rsp_pc};

endmodule

//--- hdl/pc_sequencer.sv
`timescale 1ns/1ps

`include "fetch_defines.svh"

module pc_sequencer
    import fetch_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   rsp_valid,
    input  instr_t                 rsp_data,
    input  predecode_t             pre,
    input  release_t               rel,
    input  exec_event_t            exec,
    output logic                   fetch_req,
    output logic [`FETCH_XLEN-1:0] fetch_pc,
    output fetch_out_t             fout,
    output logic [`FETCH_XLEN-1:0] cur_pc,
    output instr_t                 rsp_word
);

    logic                   boot;
    logic                   outstanding;
    logic                   squash;
    logic [`FETCH_XLEN-1:0] pc;
    logic                   issue;
    logic [`FETCH_XLEN-1:0] issue_addr;
    logic                   pre_waits;
    logic                   fout_valid;
    logic [`FETCH_XLEN-1:0] fout_pc;
    instr_t                 fout_inst;

    assign pre_waits = pre.cls inside {cls_jalr, cls_mul, cls_div};

    always_comb begin
        issue      = 1'b0;
        issue_addr = pc;
        if (exec.redirect) begin
            // wait for the stale response if one is still out
            issue      = !outstanding || rsp_valid;
            issue_addr = exec.redirect_target;
        end else if (rsp_valid && squash) begin
            issue = 1'b1;
        end else if (rel.go) begin
            issue      = 1'b1;
            issue_addr = rel.go_target;
        end else if (pre.valid) begin
            issue      = !pre_waits && !rel.hold;
            issue_addr = pre.next_pc;
        end else if (boot) begin
            issue = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            boot        <= 1'b1;
            outstanding <= 1'b0;
            squash      <= 1'b0;
            pc          <= `FETCH_RESET_PC;
            fetch_req   <= 1'b0;
            fout_valid  <= 1'b0;
        end else begin
            boot        <= 1'b0;
            outstanding <= issue || (outstanding && !rsp_valid);
            fetch_req   <= issue;
            fout_valid  <= rsp_valid && !squash && !exec.redirect;
            if (exec.redirect) begin
                squash <= outstanding && !rsp_valid;
            end else if (rsp_valid) begin
                squash <= 1'b0;
            end
            // redirect target parks here until the stale response drains
            if (issue || exec.redirect) begin
                pc <= issue_addr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            fetch_pc <= issue_addr;
        end
        if (rsp_valid) begin
            fout_pc   <= pc;
            fout_inst <= rsp_data;
        end
    end

    assign fout   = '{valid: fout_valid, pc: fout_pc, inst: fout_inst};
    assign cur_pc = pc;

    // squashed words decode as seq so no wait is entered
    assign rsp_word = squash ? instr_t'('0) : rsp_data;

    a_single_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_req |=> !fetch_req until rsp_valid)
        else $error("fetch issued while another is outstanding");

    a_rsp_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> outstanding)
        else $error("memory response without an outstanding fetch");

endmodule

//--- hdl/stall_tracker.sv
`timescale 1ns/1ps

`include "fetch_defines.svh"

module stall_tracker
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  predecode_t  pre,
    input  exec_event_t exec,
    output release_t    rel
);

    typedef enum logic [1:0] {
        wait_none,
        wait_jalr,
        wait_mul,
        wait_div
    } wait_e;

    wait_e                  state;
    wait_e                  state_nxt;
    logic [`FETCH_XLEN-1:0] wait_pc;
    logic                   done_match;
    logic                   enter;

    always_comb begin
        case (state)
            wait_jalr: done_match = exec.jalr_valid;
            wait_mul:  done_match = exec.mul_done;
            wait_div:  done_match = exec.div_done;
            default:   done_match = 1'b0;
        endcase
    end

    assign enter = pre.valid && (state == wait_none);

    always_comb begin
        state_nxt = state;
        if (exec.redirect || done_match) begin
            state_nxt = wait_none;
        end else if (enter) begin
            case (pre.cls)
                cls_jalr: state_nxt = wait_jalr;
                cls_mul:  state_nxt = wait_mul;
                cls_div:  state_nxt = wait_div;
                default:  state_nxt = wait_none;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= wait_none;
        end else begin
            state <= state_nxt;
        end
    end

    // pc of the instruction being waited on
    always_ff @(posedge clk) begin
        if (enter) begin
            wait_pc <= pre.pc;
        end
    end

    assign rel = '{
        hold:      (state != wait_none),
        go:        done_match,
        go_target: (state == wait_jalr) ? exec.jalr_target : wait_pc + `FETCH_XLEN'd4
    };

    // front end issues nothing while waiting so no new decode can arrive
    a_no_decode_while_held: assert property (@(posedge clk) disable iff (!rst_n)
        rel.hold |-> !pre.valid)
        else $error("instruction returned while a wait is held");

endmodule

//--- project.f
+incdir+hdl
hdl/fetch_pkg.sv
hdl/inst_predecode.sv
hdl/stall_tracker.sv
hdl/pc_sequencer.sv
hdl/fetch_unit.sv
testbench/fetch_unit_tb.sv

//--- testbench/fetch_unit_tb.sv
`timescale 1ns/1ps

`include "fetch_defines.svh"

module fetch_unit_tb
    import fetch_pkg::*;
();

    localparam int NUM_INSTR    = 200;
    localparam int RESET_CYCLES = 8;
    // about 12 cycles per instruction in the worst case and twice that as margin
    localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_INSTR * 12) * 10 * 2;
    localparam int REDIRECT_GAP = 7;

    localparam int T_RESET    = 0;
    localparam int T_SEQ      = 1;
    localparam int T_BRANCH   = 2;
    localparam int T_LONG     = 3;
    localparam int T_JALR     = 4;
    localparam int T_REDIRECT = 5;

    localparam int W_NONE = 0;
    localparam int W_JALR = 1;
    localparam int W_MUL  = 2;
    localparam int W_DIV  = 3;

    string test_names [6] = '{"reset_fetch", "sequential_and_jal", "branch_predict",
                              "long_op_hold", "jalr_wait", "redirect_squash"};

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   rsp_valid;
    instr_t                 rsp_data;
    exec_event_t            exec_ev;
    logic                   fetch_req;
    logic [`FETCH_XLEN-1:0] fetch_pc;
    fetch_out_t             fout;

    logic [15:0] lfsr = 16'd58;
    int          err_cnt [6];
    int          hits [6];
    int          cyc;
    int          rsp_count;
    int          req_seen;

    // expectations for the current cycle and what is due in the next one
    logic        exp_req;
    logic [31:0] exp_pc;
    int          exp_test;
    logic        req_due;
    logic [31:0] req_due_pc;
    int          req_due_test;
    logic        exp_fout;
    logic [31:0] exp_fout_pc;
    logic [31:0] exp_fout_word;
    int          fout_test;
    logic        fout_due;
    logic [31:0] fout_due_pc;
    logic [31:0] fout_due_word;
    int          fout_due_test;
    int          ctx_test;

    // memory and execute model state
    logic        mem_busy;
    int          mem_cnt;
    logic [31:0] mem_pc;
    logic        mem_squashed;
    logic [31:0] redir_tgt;
    int          exec_wait;
    int          exec_cnt;
    logic [31:0] wait_pc;
    logic [31:0] jalr_tgt;

    fetch_unit dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .exec      (exec_ev),
        .fetch_req (fetch_req),
        .fetch_pc  (fetch_pc),
        .fout      (fout)
    );

    always #5 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[14:0], fb};
        end
        return v;
    endfunction

    // imm[20|10:1|11|19:12] in inst[31:12]
    function automatic logic [31:0] encode_jal(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, `FETCH_OP_JAL};
    endfunction

    function automatic logic [31:0] encode_branch(input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd3, 5'd2, 3'b000, imm[4:1], imm[11], `FETCH_OP_BRANCH};
    endfunction

    task automatic report_mismatch(input int t, input string what,
                                   input logic [63:0] exp_v, input logic [63:0] act_v);
        err_cnt[t]++;
        $display("** Error [%s] %s: expected %h actual %h", test_names[t], what, exp_v, act_v);
    endtask

    task automatic schedule_fetch(input logic [31:0] pc, input int t);
        req_due      = 1'b1;
        req_due_pc   = pc;
        req_due_test = t;
        hits[t]++;
    endtask

    always @(negedge clk) begin : drive_p
        logic [2:0]  kind;
        logic [15:0] r;
        logic [31:0] off;
        logic [31:0] word;
        int          t;

        cyc++;
        exp_req   = req_due;
        exp_pc    = req_due_pc;
        exp_test  = req_due_test;
        req_due   = 1'b0;
        exp_fout      = fout_due;
        exp_fout_pc   = fout_due_pc;
        exp_fout_word = fout_due_word;
        fout_test     = fout_due_test;
        fout_due      = 1'b0;
        rsp_valid          = 1'b0;
        exec_ev.mul_done   = 1'b0;
        exec_ev.div_done   = 1'b0;
        exec_ev.jalr_valid = 1'b0;
        exec_ev.redirect   = 1'b0;
        if (cyc == RESET_CYCLES) begin
            rst_n = 1'b1;
            schedule_fetch(`FETCH_RESET_PC, T_RESET);
        end else if (cyc > RESET_CYCLES) begin
            // execute completes the instruction the front end waits on
            if (exec_wait != W_NONE) begin
                exec_cnt--;
                if (exec_cnt == 0) begin
                    case (exec_wait)
                        W_JALR: begin
                            exec_ev.jalr_valid  = 1'b1;
                            exec_ev.jalr_target = jalr_tgt;
                            schedule_fetch(jalr_tgt, T_JALR);
                        end
                        W_MUL: begin
                            exec_ev.mul_done = 1'b1;
                            schedule_fetch(wait_pc + 32'd4, T_LONG);
                        end
                        default: begin
                            exec_ev.div_done = 1'b1;
                            schedule_fetch(wait_pc + 32'd4, T_LONG);
                        end
                    endcase
                    exec_wait = W_NONE;
                end
            end
            if (mem_busy) begin
                mem_cnt--;
                if (mem_cnt == 0) begin
                    mem_busy = 1'b0;
                    rsp_count++;
                    kind = rand_bits(3);
                    r    = rand_bits(10);
                    off  = {{20{r[9]}}, r[9:0], 2'b00};
                    case (kind)
                        3'd3: word = encode_jal(off[20:0]);
                        3'd4: word = encode_branch(off[12:0]);
                        3'd5: word = {12'h000, 5'd1, 3'b000, 5'd0, `FETCH_OP_JALR};
                        3'd6: word = {`FETCH_F7_MULDIV, 5'd3, 5'd2, 1'b0, r[1:0], 5'd1,
                                      `FETCH_OP_OP};
                        3'd7: word = {`FETCH_F7_MULDIV, 5'd3, 5'd2, 1'b1, r[1:0], 5'd1,
                                      `FETCH_OP_OP};
                        default: word = {7'b0, 5'd3, 5'd2, 3'b000, 5'd1, `FETCH_OP_OP};
                    endcase
                    rsp_valid = 1'b1;
                    rsp_data  = instr_t'(word);
                    if (mem_squashed) begin
                        fout_due_test = T_REDIRECT;
                        schedule_fetch(redir_tgt, T_REDIRECT);
                    end else begin
                        case (kind)
                            3'd3: t = T_SEQ;
                            3'd4: t = T_BRANCH;
                            3'd5: t = T_JALR;
                            3'd6: t = T_LONG;
                            3'd7: t = T_LONG;
                            default: t = T_SEQ;
                        endcase
                        ctx_test      = t;
                        fout_due      = 1'b1;
                        fout_due_pc   = mem_pc;
                        fout_due_word = word;
                        fout_due_test = t;
                        if (kind == 3'd3) begin
                            schedule_fetch(mem_pc + off, t);
                        end else if (kind == 3'd4) begin
                            // backward taken and forward falls through
                            schedule_fetch(off[31] ? mem_pc + off : mem_pc + 32'd4, t);
                        end else if (kind >= 3'd5) begin
                            exec_wait = (kind == 3'd5) ? W_JALR : (kind == 3'd6) ? W_MUL : W_DIV;
                            exec_cnt  = 1 + rand_bits(2);
                            wait_pc   = mem_pc;
                            r         = rand_bits(14);
                            jalr_tgt  = {16'h8000, r[13:0], 2'b00};
                        end else begin
                            schedule_fetch(mem_pc + 32'd4, t);
                        end
                    end
                end
            end
            if (fetch_req) begin
                mem_busy     = 1'b1;
                mem_cnt      = 1 + rand_bits(2);
                mem_pc       = exp_pc;
                req_seen++;
                mem_squashed = (req_seen % REDIRECT_GAP == 0);
                if (mem_squashed) begin
                    r                       = rand_bits(14);
                    redir_tgt               = {16'h9000, r[13:0], 2'b00};
                    exec_ev.redirect        = 1'b1;
                    exec_ev.redirect_target = redir_tgt;
                    ctx_test                = T_REDIRECT;
                end
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !fetch_req && !fout.valid)
        else report_mismatch(T_RESET, "fetch_req/fout.valid", 64'd0,
                             {$sampled(fetch_req), $sampled(fout.valid)});

    a_fetch_due: assert property (@(posedge clk) disable iff (!rst_n) exp_req |-> fetch_req)
        else report_mismatch(exp_test, "fetch_req", 64'd1, $sampled(fetch_req));

    a_fetch_addr: assert property (@(posedge clk) disable iff (!rst_n)
        exp_req && fetch_req |-> fetch_pc == exp_pc)
        else report_mismatch(exp_test, "fetch_pc", exp_pc, $sampled(fetch_pc));

    a_no_stray_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        !exp_req |-> !fetch_req)
        else report_mismatch(ctx_test, "fetch_req", 64'd0, $sampled(fetch_req));

    a_fout_valid: assert property (@(posedge clk) disable iff (!rst_n) fout.valid == exp_fout)
        else report_mismatch(fout_test, "fout.valid", exp_fout, $sampled(fout.valid));

    a_fout_data: assert property (@(posedge clk) disable iff (!rst_n)
        exp_fout && fout.valid |-> fout.pc == exp_fout_pc && fout.inst == exp_fout_word)
        else report_mismatch(fout_test, "fout pc/inst", {exp_fout_pc, exp_fout_word},
                             {$sampled(fout.pc), $sampled(fout.inst)});

    initial begin
        #(TIMEOUT_NS);
        $display("run timed out after %0d ns with %0d of %0d responses",
                 TIMEOUT_NS, rsp_count, NUM_INSTR);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : main_p
        int missed;
        int total;

        rst_n     = 1'b0;
        rsp_valid = 1'b0;
        rsp_data  = '0;
        exec_ev   = '0;
        req_due   = 1'b0;
        fout_due  = 1'b0;
        mem_busy  = 1'b0;
        exec_wait = W_NONE;
        ctx_test  = T_RESET;
        fout_due_test = T_SEQ;
        missed    = 0;
        total     = 0;
        wait (rsp_count >= NUM_INSTR);
        repeat (4) @(negedge clk);
        for (int i = 0; i < 6; i++) begin
            if (hits[i] == 0) begin
                $display("stimulus never reached %s", test_names[i]);
                missed++;
            end
            total += err_cnt[i];
        end
        $display("errors: %s=%0d %s=%0d %s=%0d %s=%0d %s=%0d %s=%0d, total %0d",
                 test_names[0], err_cnt[0], test_names[1], err_cnt[1],
                 test_names[2], err_cnt[2], test_names[3], err_cnt[3],
                 test_names[4], err_cnt[4], test_names[5], err_cnt[5], total);
        if (total == 0 && missed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
